// ==== hw/queue_cfg_pkg.sv ====
package queue_cfg_pkg;

    // switch geometry
    localparam int NUM_PORTS  = 4;
    // priority 0 is served first
    localparam int NUM_PRIOS  = 4;
    // queue id = port * NUM_PRIOS + prio
    localparam int NUM_QUEUES = NUM_PORTS * NUM_PRIOS;

    // buffer address space, 64 cells
    localparam int CELL_AW     = 6;
    localparam int FRAME_CNT_W = 7;

    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int PRIO_W = $clog2(NUM_PRIOS);
    localparam int QID_W  = $clog2(NUM_QUEUES);

    typedef logic [PORT_W-1:0]  port_t;
    typedef logic [PRIO_W-1:0]  prio_t;
    typedef logic [QID_W-1:0]   qid_t;
    typedef logic [CELL_AW-1:0] cell_addr_t;

endpackage

// ==== hw/link_pkg.sv ====
package link_pkg;

    import queue_cfg_pkg::*;

    // one link entry per buffer cell
    localparam int LINK_DEPTH = 1 << CELL_AW;

    // entry at address a describes cell a
    typedef struct packed {
        cell_addr_t next;   // successor in the queue
        logic       last;   // cell a closes a frame
    } link_entry_t;

endpackage

// ==== hw/link_mem_if.sv ====
`timescale 1ns/1ps

interface link_mem_if
    import queue_cfg_pkg::*, link_pkg::*;
();

    logic        req;
    logic        we;
    cell_addr_t  addr;
    link_entry_t wdata;

    // grant is combinational, read data comes one cycle later
    logic        gnt;
    link_entry_t rdata;
    logic        rvld;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvld
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvld
    );

endinterface

// ==== hw/queue_table_if.sv ====
`timescale 1ns/1ps

interface queue_table_if
    import queue_cfg_pkg::*;
();

    // enqueue side
    logic       append;
    qid_t       enq_qid;
    cell_addr_t enq_addr;
    logic       enq_last;
    cell_addr_t enq_tail;
    logic       enq_empty;
    logic       enq_tail_last;

    // dequeue side
    logic       pop;
    qid_t       deq_qid;
    cell_addr_t deq_new_head;
    logic       deq_frame_done;
    cell_addr_t deq_head;
    cell_addr_t deq_tail;
    logic       deq_empty;

    modport enq (
        output append, enq_qid, enq_addr, enq_last,
        input  enq_tail, enq_empty, enq_tail_last
    );

    modport deq (
        output pop, deq_qid, deq_new_head, deq_frame_done,
        input  deq_head, deq_tail, deq_empty
    );

    modport tbl (
        input  append, enq_qid, enq_addr, enq_last,
        input  pop, deq_qid, deq_new_head, deq_frame_done,
        output enq_tail, enq_empty, enq_tail_last,
        output deq_head, deq_tail, deq_empty
    );

endinterface

// ==== hw/queue_table.sv ====
`timescale 1ns/1ps

module queue_table
    import queue_cfg_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    queue_table_if.tbl           tab,
    output logic [NUM_PORTS-1:0] o_pending,
    output prio_t                o_top_prio [NUM_PORTS]
);

    cell_addr_t             head      [NUM_QUEUES];
    cell_addr_t             tail      [NUM_QUEUES];
    logic [FRAME_CNT_W-1:0] frame_cnt [NUM_QUEUES];
    logic [NUM_QUEUES-1:0]  q_empty;
    logic [NUM_QUEUES-1:0]  tail_last;
    logic [NUM_QUEUES-1:0]  cnt_inc;
    logic [NUM_QUEUES-1:0]  cnt_dec;
    logic                   pop_drains;
    logic                   same_q;

    // popping the tail empties the queue unless a cell lands in it this cycle
    assign pop_drains = tab.pop && (head[tab.deq_qid] == tail[tab.deq_qid]);
    assign same_q     = tab.append && tab.pop && (tab.enq_qid == tab.deq_qid);

    assign tab.enq_tail      = tail[tab.enq_qid];
    assign tab.enq_empty     = q_empty[tab.enq_qid];
    assign tab.enq_tail_last = tail_last[tab.enq_qid];
    assign tab.deq_head      = head[tab.deq_qid];
    assign tab.deq_tail      = tail[tab.deq_qid];
    assign tab.deq_empty     = q_empty[tab.deq_qid];

    always_comb begin
        cnt_inc = '0;
        cnt_dec = '0;
        if (tab.append && tab.enq_last)
            cnt_inc[tab.enq_qid] = 1'b1;
        if (tab.pop && tab.deq_frame_done)
            cnt_dec[tab.deq_qid] = 1'b1;
    end

    // append wins on the head of a drained queue
    always_ff @(posedge i_clk) begin
        if (tab.pop)
            head[tab.deq_qid] <= tab.deq_new_head;
        if (tab.append) begin
            tail[tab.enq_qid] <= tab.enq_addr;
            if (q_empty[tab.enq_qid] || (same_q && pop_drains))
                head[tab.enq_qid] <= tab.enq_addr;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            q_empty   <= '1;
            tail_last <= '0;
            frame_cnt <= '{default: '0};
        end else begin
            if (pop_drains)
                q_empty[tab.deq_qid] <= 1'b1;
            if (tab.append) begin
                q_empty[tab.enq_qid]   <= 1'b0;
                tail_last[tab.enq_qid] <= tab.enq_last;
            end
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (cnt_inc[q] && !cnt_dec[q])
                    frame_cnt[q] <= frame_cnt[q] + 1'b1;
                else if (cnt_dec[q] && !cnt_inc[q])
                    frame_cnt[q] <= frame_cnt[q] - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-port pending and top priority
    //////////////////////////////////////////////////////////////////////

    // scan downward so the lowest-numbered priority sticks
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            o_pending[p]  = 1'b0;
            o_top_prio[p] = '0;
            for (int r = NUM_PRIOS - 1; r >= 0; r--) begin
                if (frame_cnt[p * NUM_PRIOS + r] != '0) begin
                    o_pending[p]  = 1'b1;
                    o_top_prio[p] = prio_t'(r);
                end
            end
        end
    end

    a_no_cnt_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
        tab.pop && tab.deq_frame_done |-> frame_cnt[tab.deq_qid] != '0);

endmodule

// ==== hw/enqueue_engine.sv ====
`timescale 1ns/1ps

module enqueue_engine
    import queue_cfg_pkg::*, link_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_cell_vld,
    input  cell_addr_t     i_cell_addr,
    input  port_t          i_cell_port,
    input  prio_t          i_cell_prio,
    input  logic           i_cell_last,
    output logic           o_cell_rdy,
    queue_table_if.enq     tab,
    link_mem_if.requester  mem
);

    typedef enum logic {
        EQ_IDLE,
        EQ_LINK
    } eq_state_t;

    eq_state_t   state;
    logic        accept;
    cell_addr_t  link_addr;
    link_entry_t link_data;

    assign o_cell_rdy = (state == EQ_IDLE);
    assign accept     = i_cell_vld && o_cell_rdy;

    // table update happens on the acceptance edge itself
    assign tab.append   = accept;
    assign tab.enq_qid  = {i_cell_port, i_cell_prio};
    assign tab.enq_addr = i_cell_addr;
    assign tab.enq_last = i_cell_last;

    // chain the old tail to the new cell
    assign mem.req   = (state == EQ_LINK);
    assign mem.we    = 1'b1;
    assign mem.addr  = link_addr;
    assign mem.wdata = link_data;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= EQ_IDLE;
        end else begin
            case (state)
                EQ_IDLE: begin
                    // first cell of an empty queue needs no link
                    if (accept && !tab.enq_empty)
                        state <= EQ_LINK;
                end
                EQ_LINK: begin
                    if (mem.gnt)
                        state <= EQ_IDLE;
                end
                default: state <= EQ_IDLE;
            endcase
        end
    end

    // old tail keeps its own last flag, gains a successor
    always_ff @(posedge i_clk) begin
        if (accept) begin
            link_addr      <= tab.enq_tail;
            link_data.next <= i_cell_addr;
            link_data.last <= tab.enq_tail_last;
        end
    end

endmodule

// ==== hw/dequeue_engine.sv ====
`timescale 1ns/1ps

module dequeue_engine
    import queue_cfg_pkg::*, link_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_deq_vld,
    input  port_t                i_deq_port,
    input  logic [NUM_PORTS-1:0] i_pending,
    input  prio_t                i_top_prio [NUM_PORTS],
    input  logic                 i_out_rdy,
    output logic                 o_out_vld,
    output cell_addr_t           o_out_addr,
    output logic                 o_out_last,
    output logic                 o_deq_busy,
    queue_table_if.deq           tab,
    link_mem_if.requester        mem
);

    typedef enum logic [1:0] {
        DQ_IDLE,
        DQ_READ,
        DQ_WAIT,
        DQ_PRESENT
    } dq_state_t;

    dq_state_t  state;
    qid_t       qid;
    cell_addr_t next_addr;
    logic       next_vld;
    logic       out_last;
    logic       at_tail;
    logic       out_hs;

    assign at_tail = (tab.deq_head == tab.deq_tail);
    assign out_hs  = (state == DQ_PRESENT) && i_out_rdy;

    assign o_out_vld  = (state == DQ_PRESENT);
    assign o_out_last = out_last && o_out_vld;
    assign o_deq_busy = (state != DQ_IDLE);

    // each handshake pops the head
    assign tab.pop            = out_hs;
    assign tab.deq_qid        = qid;
    assign tab.deq_frame_done = out_last;
    // without a link read the successor is whatever became the tail
    assign tab.deq_new_head   = next_vld ? next_addr : tab.deq_tail;

    assign mem.req   = (state == DQ_READ) && !at_tail && !tab.deq_empty;
    assign mem.we    = 1'b0;
    assign mem.addr  = tab.deq_head;
    assign mem.wdata = '0;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= DQ_IDLE;
            qid      <= '0;
            next_vld <= 1'b0;
            out_last <= 1'b0;
        end else begin
            case (state)
                DQ_IDLE: begin
                    if (i_deq_vld && i_pending[i_deq_port]) begin
                        qid   <= {i_deq_port, i_top_prio[i_deq_port]};
                        state <= DQ_READ;
                    end
                end
                DQ_READ: begin
                    if (tab.deq_empty) begin
                        state <= DQ_IDLE;
                    end else if (at_tail) begin
                        // tail of a complete frame is its last cell
                        out_last <= 1'b1;
                        next_vld <= 1'b0;
                        state    <= DQ_PRESENT;
                    end else if (mem.gnt) begin
                        state <= DQ_WAIT;
                    end
                end
                DQ_WAIT: begin
                    if (mem.rvld) begin
                        out_last <= mem.rdata.last;
                        next_vld <= 1'b1;
                        state    <= DQ_PRESENT;
                    end
                end
                DQ_PRESENT: begin
                    if (!next_vld && tab.deq_tail != o_out_addr)
                        next_vld <= 1'b1;
                    if (i_out_rdy)
                        state <= out_last ? DQ_IDLE : DQ_READ;
                end
                default: state <= DQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == DQ_READ)
            o_out_addr <= tab.deq_head;
        if (state == DQ_WAIT && mem.rvld)
            next_addr <= mem.rdata.next;
        else if (state == DQ_PRESENT && !next_vld)
            next_addr <= tab.deq_tail;
    end

    a_out_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_out_vld && !i_out_rdy |=> $stable(o_out_addr) && $stable(o_out_last));

endmodule

// ==== hw/link_mem_arbiter.sv ====
`timescale 1ns/1ps

module link_mem_arbiter
    import queue_cfg_pkg::*, link_pkg::*;
(
    link_mem_if.arbiter enq_mem,
    link_mem_if.arbiter deq_mem,
    output logic        o_ram_en,
    output logic        o_ram_we,
    output cell_addr_t  o_ram_addr,
    output link_entry_t o_ram_wdata,
    input  link_entry_t i_ram_rdata,
    input  logic        i_clk,
    input  logic        i_rst
);

    logic enq_rd_pend;
    logic deq_rd_pend;

    // enqueue first, so a link lands before anyone reads it
    assign enq_mem.gnt = enq_mem.req;
    assign deq_mem.gnt = deq_mem.req && !enq_mem.req;

    assign o_ram_en    = enq_mem.req || deq_mem.req;
    assign o_ram_we    = enq_mem.req ? enq_mem.we    : deq_mem.we;
    assign o_ram_addr  = enq_mem.req ? enq_mem.addr  : deq_mem.addr;
    assign o_ram_wdata = enq_mem.req ? enq_mem.wdata : deq_mem.wdata;

    //////////////////////////////////////////////////////////////////////
    // read return
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            enq_rd_pend <= 1'b0;
            deq_rd_pend <= 1'b0;
        end else begin
            enq_rd_pend <= enq_mem.gnt && !enq_mem.we;
            deq_rd_pend <= deq_mem.gnt && !deq_mem.we;
        end
    end

    assign enq_mem.rdata = i_ram_rdata;
    assign enq_mem.rvld  = enq_rd_pend;
    assign deq_mem.rdata = i_ram_rdata;
    assign deq_mem.rvld  = deq_rd_pend;

    // a stalled dequeue request keeps its address until granted
    a_deq_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
        deq_mem.req && !deq_mem.gnt |=> deq_mem.req && $stable(deq_mem.addr));

endmodule

// ==== hw/link_ram.sv ====
`timescale 1ns/1ps

module link_ram
    import queue_cfg_pkg::*, link_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_en,
    input  logic        i_we,
    input  cell_addr_t  i_addr,
    input  link_entry_t i_wdata,
    output link_entry_t o_rdata
);

    link_entry_t mem [LINK_DEPTH];

    // read data one cycle after the enable
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we)
                mem[i_addr] <= i_wdata;
            else
                o_rdata <= mem[i_addr];
        end
    end

    a_addr_known: assert property (@(posedge i_clk)
        i_en |-> !$isunknown(i_addr));

endmodule

// ==== hw/pqm_top.sv ====
`timescale 1ns/1ps

module pqm_top
    import queue_cfg_pkg::*, link_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_cell_vld,
    input  cell_addr_t           i_cell_addr,
    input  port_t                i_cell_port,
    input  prio_t                i_cell_prio,
    input  logic                 i_cell_last,
    output logic                 o_cell_rdy,
    input  logic                 i_deq_vld,
    input  port_t                i_deq_port,
    input  logic                 i_out_rdy,
    output logic                 o_out_vld,
    output cell_addr_t           o_out_addr,
    output logic                 o_out_last,
    output logic                 o_deq_busy,
    output logic [NUM_PORTS-1:0] o_pending,
    output prio_t                o_top_prio [NUM_PORTS]
);

    logic        ram_en;
    logic        ram_we;
    cell_addr_t  ram_addr;
    link_entry_t ram_wdata;
    link_entry_t ram_rdata;

    queue_table_if u_tab_if ();
    link_mem_if    u_enq_mem_if ();
    link_mem_if    u_deq_mem_if ();

    queue_table u_queue_table (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .tab        (u_tab_if.tbl),
        .o_pending  (o_pending),
        .o_top_prio (o_top_prio)
    );

    enqueue_engine u_enqueue_engine (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cell_vld  (i_cell_vld),
        .i_cell_addr (i_cell_addr),
        .i_cell_port (i_cell_port),
        .i_cell_prio (i_cell_prio),
        .i_cell_last (i_cell_last),
        .o_cell_rdy  (o_cell_rdy),
        .tab         (u_tab_if.enq),
        .mem         (u_enq_mem_if.requester)
    );

    dequeue_engine u_dequeue_engine (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_deq_vld  (i_deq_vld),
        .i_deq_port (i_deq_port),
        .i_pending  (o_pending),
        .i_top_prio (o_top_prio),
        .i_out_rdy  (i_out_rdy),
        .o_out_vld  (o_out_vld),
        .o_out_addr (o_out_addr),
        .o_out_last (o_out_last),
        .o_deq_busy (o_deq_busy),
        .tab        (u_tab_if.deq),
        .mem        (u_deq_mem_if.requester)
    );

    link_mem_arbiter u_link_mem_arbiter (
        .enq_mem     (u_enq_mem_if.arbiter),
        .deq_mem     (u_deq_mem_if.arbiter),
        .o_ram_en    (ram_en),
        .o_ram_we    (ram_we),
        .o_ram_addr  (ram_addr),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata),
        .i_clk       (i_clk),
        .i_rst       (i_rst)
    );

    link_ram u_link_ram (
        .i_clk   (i_clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

endmodule

// ==== bench/tb_pqm.sv ====
`timescale 1ns/1ps

module tb_pqm
    import queue_cfg_pkg::*;
();

    // 40 frames x 6 cells x 8 cycles, doubled, plus reset margin
    localparam int MAX_CYCLES = 2 * 40 * 6 * 8 + 160;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_cell_vld;
    cell_addr_t           i_cell_addr;
    port_t                i_cell_port;
    prio_t                i_cell_prio;
    logic                 i_cell_last;
    logic                 o_cell_rdy;
    logic                 i_deq_vld;
    port_t                i_deq_port;
    logic                 i_out_rdy;
    logic                 o_out_vld;
    cell_addr_t           o_out_addr;
    logic                 o_out_last;
    logic                 o_deq_busy;
    logic [NUM_PORTS-1:0] o_pending;
    prio_t                o_top_prio [NUM_PORTS];

    // model entries hold {last, addr}
    logic [CELL_AW:0]     model_q [NUM_QUEUES][$];
    int                   mcnt [NUM_QUEUES];
    cell_addr_t           free_list [$];
    logic [CELL_AW:0]     ent;
    qid_t                 act_qid;
    logic                 exp_busy;
    logic [NUM_PORTS-1:0] exp_pending;
    prio_t                exp_top_prio [NUM_PORTS];
    cell_addr_t           exp_addr;
    logic                 exp_last;

    logic rdy_random;
    int   errors;
    int   tests_run;
    int   tests_failed;
    int   cycles;

    pqm_top u_pqm_top (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cell_vld  (i_cell_vld),
        .i_cell_addr (i_cell_addr),
        .i_cell_port (i_cell_port),
        .i_cell_prio (i_cell_prio),
        .i_cell_last (i_cell_last),
        .o_cell_rdy  (o_cell_rdy),
        .i_deq_vld   (i_deq_vld),
        .i_deq_port  (i_deq_port),
        .i_out_rdy   (i_out_rdy),
        .o_out_vld   (o_out_vld),
        .o_out_addr  (o_out_addr),
        .o_out_last  (o_out_last),
        .o_deq_busy  (o_deq_busy),
        .o_pending   (o_pending),
        .o_top_prio  (o_top_prio)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // sink ready is random only in the back-pressure phases
    always @(posedge i_clk) begin
        #2;
        i_out_rdy = rdy_random ? 1'($urandom % 2) : 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        if (!i_rst) begin
            // request sees pending from before this edge
            if (i_deq_vld && !exp_busy && exp_pending[i_deq_port]) begin
                act_qid  = qid_t'(i_deq_port * NUM_PRIOS + exp_top_prio[i_deq_port]);
                exp_busy = 1'b1;
            end
            if (o_out_vld && i_out_rdy) begin
                if (model_q[act_qid].size() == 0) begin
                    report_fault("output cell seen while the model queue is empty");
                end else begin
                    ent = model_q[act_qid].pop_front();
                    free_list.push_back(ent[CELL_AW-1:0]);
                    if (ent[CELL_AW]) begin
                        mcnt[act_qid]--;
                        exp_busy = 1'b0;
                    end
                end
            end
            if (i_cell_vld && o_cell_rdy) begin
                ent = {i_cell_last, i_cell_addr};
                model_q[i_cell_port * NUM_PRIOS + i_cell_prio].push_back(ent);
                if (i_cell_last)
                    mcnt[i_cell_port * NUM_PRIOS + i_cell_prio]++;
            end
            // first priority upward with a whole frame wins
            for (int p = 0; p < NUM_PORTS; p++) begin
                exp_pending[p]  = 1'b0;
                exp_top_prio[p] = '0;
                for (int r = 0; r < NUM_PRIOS; r++) begin
                    if (!exp_pending[p] && mcnt[p * NUM_PRIOS + r] > 0) begin
                        exp_pending[p]  = 1'b1;
                        exp_top_prio[p] = prio_t'(r);
                    end
                end
            end
            if (model_q[act_qid].size() != 0)
                {exp_last, exp_addr} = model_q[act_qid][0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_rst_rdy: assert property (@(posedge i_clk) $fell(i_rst) |-> o_cell_rdy)
        else report_mismatch("o_cell_rdy", 1, $sampled(o_cell_rdy));
    a_rst_vld: assert property (@(posedge i_clk) $fell(i_rst) |-> !o_out_vld)
        else report_mismatch("o_out_vld", 0, $sampled(o_out_vld));

    a_pending: assert property (@(posedge i_clk) disable iff (i_rst)
        o_pending == exp_pending)
        else report_mismatch("o_pending", $sampled(exp_pending), $sampled(o_pending));

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_prio_chk
        a_top_prio: assert property (@(posedge i_clk) disable iff (i_rst)
            o_top_prio[g] == exp_top_prio[g])
            else report_mismatch($sformatf("o_top_prio[%0d]", g),
                $sampled(exp_top_prio[g]), $sampled(o_top_prio[g]));
    end

    a_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        o_deq_busy == exp_busy)
        else report_mismatch("o_deq_busy", $sampled(exp_busy), $sampled(o_deq_busy));

    a_out_addr: assert property (@(posedge i_clk) disable iff (i_rst)
        o_out_vld && i_out_rdy |-> o_out_addr == exp_addr)
        else report_mismatch("o_out_addr", $sampled(exp_addr), $sampled(o_out_addr));
    a_out_last: assert property (@(posedge i_clk) disable iff (i_rst)
        o_out_vld && i_out_rdy |-> o_out_last == exp_last)
        else report_mismatch("o_out_last", $sampled(exp_last), $sampled(o_out_last));

    a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_out_vld && !i_out_rdy |=> o_out_vld && $stable(o_out_addr) && $stable(o_out_last))
        else report_fault("output cell changed while the sink held it back");

    a_end_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        o_out_vld && i_out_rdy && o_out_last |=> !o_deq_busy)
        else report_fault("o_deq_busy still high in the cycle after the last cell");

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - errs_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks start and end 2 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge i_clk);
        #2;
    endtask

    task automatic send_cell(input int port, input int prio, input logic last);
        int         idx;
        cell_addr_t addr;
        while (!o_cell_rdy)
            step();
        idx  = $urandom % free_list.size();
        addr = free_list[idx];
        free_list.delete(idx);
        i_cell_vld  = 1'b1;
        i_cell_addr = addr;
        i_cell_port = port_t'(port);
        i_cell_prio = prio_t'(prio);
        i_cell_last = last;
        step();
        i_cell_vld  = 1'b0;
    endtask

    task automatic send_frame(input int port, input int prio, input int len);
        for (int i = 0; i < len; i++)
            send_cell(port, prio, i == len - 1);
    endtask

    task automatic send_random_frames(input int num);
        for (int f = 0; f < num; f++)
            send_frame($urandom % NUM_PORTS, $urandom % NUM_PRIOS, 1 + $urandom % 6);
    endtask

    task automatic drain_port(input int port);
        while (o_deq_busy)
            step();
        i_deq_vld  = 1'b1;
        i_deq_port = port_t'(port);
        step();
        i_deq_vld  = 1'b0;
        while (o_deq_busy)
            step();
    endtask

    task automatic drain_all();
        for (int p = 0; p < NUM_PORTS; p++) begin
            while (exp_pending[p])
                drain_port(p);
        end
    endtask

    initial begin
        int errs;
        void'($urandom(17));
        i_rst       = 1'b1;
        i_cell_vld  = 1'b0;
        i_cell_addr = '0;
        i_cell_port = '0;
        i_cell_prio = '0;
        i_cell_last = 1'b0;
        i_deq_vld   = 1'b0;
        i_deq_port  = '0;
        i_out_rdy   = 1'b1;
        rdy_random  = 1'b0;
        exp_busy    = 1'b0;
        exp_pending = '0;
        exp_addr    = '0;
        exp_last    = 1'b0;
        act_qid     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        for (int q = 0; q < NUM_QUEUES; q++)
            mcnt[q] = 0;
        for (int p = 0; p < NUM_PORTS; p++)
            exp_top_prio[p] = '0;
        for (int a = 0; a < (1 << CELL_AW); a++)
            free_list.push_back(cell_addr_t'(a));

        repeat (5) @(posedge i_clk);
        #2;
        i_rst = 1'b0;

        errs = errors;
        repeat (3) step();
        finish_test("reset", errs);

        // open frame first, pending must stay low until its last cell
        errs = errors;
        send_cell(1, 2, 1'b0);
        send_cell(1, 2, 1'b0);
        repeat (3) step();
        send_cell(1, 2, 1'b1);
        send_frame(1, 3, 2);
        send_frame(1, 1, 3);
        send_frame(2, 0, 1);
        repeat (2) step();
        finish_test("pending", errs);

        errs = errors;
        drain_port(3);
        repeat (2) step();
        drain_port(1);
        drain_port(1);
        drain_port(1);
        drain_port(2);
        finish_test("priority", errs);

        errs = errors;
        send_frame(0, 0, 4);
        send_frame(0, 0, 2);
        send_frame(0, 2, 3);
        send_random_frames(6);
        drain_all();
        finish_test("order", errs);

        // enqueue keeps running while port 0 drains
        errs = errors;
        rdy_random = 1'b1;
        send_frame(0, 0, 3);
        send_frame(0, 0, 5);
        fork
            send_random_frames(4);
            begin
                drain_port(0);
                drain_port(0);
            end
        join
        drain_all();
        finish_test("backpressure", errs);

        errs = errors;
        send_frame(3, 1, 1);
        send_frame(3, 1, 6);
        drain_all();
        rdy_random = 1'b0;
        repeat (3) step();
        finish_test("frame end", errs);

        $display("summary: %0d tests run, %0d failed, %0d errors",
            tests_run, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== list.f ====
hw/queue_cfg_pkg.sv
hw/link_pkg.sv
hw/link_mem_if.sv
hw/queue_table_if.sv
hw/queue_table.sv
hw/enqueue_engine.sv
hw/dequeue_engine.sv
hw/link_mem_arbiter.sv
hw/link_ram.sv
hw/pqm_top.sv
bench/tb_pqm.sv
